// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_uart_apb
FILELIST  ?= filelist.f
PASS_MSG  := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: filelist.f
src/uart_apb_pkg.sv
src/reg_bus_if.sv
src/apb_decode.sv
src/register_file.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_status.sv
src/uart_apb_top.sv
testbench/uart_apb_checker.sv
testbench/tb_uart_apb.sv

// File: src/apb_decode.sv
`timescale 1ns/1ps

module apb_decode import uart_apb_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  reg_addr_t  paddr_i,
    input  reg_word_t  pwdata_i,
    input  byte_strb_t pstrb_i,
    output reg_word_t  prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,
    reg_bus_if.decode  bus
);

    apb_state_e state, state_nxt;
    logic       access;

    assign access = psel_i & penable_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (psel_i && !penable_i) state_nxt = ACCESS;   // Setup phase seen.
            ACCESS: begin
                if (access) begin
                    state_nxt = DONE;
                end else if (!psel_i) begin
                    state_nxt = IDLE;
                end
            end
            DONE:    state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign bus.addr   = paddr_i;
    assign bus.wr_rd  = pwrite_i;
    assign bus.wdata  = pwdata_i;
    assign bus.strobe = pstrb_i;
    assign bus.en     = (state == ACCESS) & access;   // First access cycle only.

    assign pready_o  = (state == DONE);
    assign prdata_o  = bus.rdata;
    assign pslverr_o = pready_o & bus.addr_err;

    a_pready_in_access: assert property (@(posedge clk) disable iff (!reset_n)
        pready_o |-> (psel_i && penable_i));

endmodule

// File: src/reg_bus_if.sv
`timescale 1ns/1ps

interface reg_bus_if import uart_apb_pkg::*; ();

    reg_addr_t  addr;
    logic       wr_rd;      // High for a write.
    logic       en;         // One-cycle access pulse.
    reg_word_t  wdata;
    byte_strb_t strobe;
    reg_word_t  rdata;
    logic       addr_err;

    modport decode (
        output addr, wr_rd, en, wdata, strobe,
        input  rdata, addr_err
    );

    modport regs (
        input  addr, wr_rd, en, wdata, strobe,
        output rdata, addr_err
    );

endinterface

// File: src/register_file.sv
`timescale 1ns/1ps

module register_file import uart_apb_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    reg_bus_if.regs   bus,
    output reg_word_t tdr_o,
    output reg_word_t lcr_o,
    output reg_word_t ocr_o,
    output reg_word_t fcr_o,
    output reg_word_t ier_o,
    output reg_word_t hcr_o,
    input  reg_word_t rdr_i,
    input  reg_word_t lsr_i,
    input  reg_word_t iir_i,
    output logic      rdr_read_o
);

    logic wr_en;
    logic rd_en;

    // Replace only the strobed byte lanes.
    function automatic reg_word_t merge_bytes(reg_word_t old_w, reg_word_t new_w,
                                              byte_strb_t strb);
        reg_word_t res;
        res = old_w;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign wr_en = bus.en & bus.wr_rd;
    assign rd_en = bus.en & ~bus.wr_rd;

    assign rdr_read_o = rd_en & (bus.addr == ADDR_RDR);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tdr_o        <= '0;
            lcr_o        <= '0;
            ocr_o        <= '0;
            fcr_o        <= '0;
            ier_o        <= '0;
            hcr_o        <= '0;
            bus.rdata    <= '0;
            bus.addr_err <= 1'b0;
        end else begin
            if (ocr_o[OCR_START]) begin
                ocr_o[OCR_START] <= 1'b0;   // Start request lasts one cycle.
            end
            if (wr_en) begin
                bus.addr_err <= 1'b0;
                case (bus.addr)
                    ADDR_TDR: tdr_o <= merge_bytes(tdr_o, bus.wdata, bus.strobe);
                    ADDR_LCR: lcr_o <= merge_bytes(lcr_o, bus.wdata, bus.strobe);
                    ADDR_OCR: ocr_o <= merge_bytes(ocr_o, bus.wdata, bus.strobe);
                    ADDR_FCR: fcr_o <= merge_bytes(fcr_o, bus.wdata, bus.strobe);
                    ADDR_IER: ier_o <= merge_bytes(ier_o, bus.wdata, bus.strobe);
                    ADDR_HCR: hcr_o <= merge_bytes(hcr_o, bus.wdata, bus.strobe);
                    ADDR_RDR, ADDR_LSR, ADDR_IIR: bus.addr_err <= 1'b1;   // Read-only.
                    default:  bus.addr_err <= 1'b1;
                endcase
            end else if (rd_en) begin
                bus.addr_err <= 1'b0;
                case (bus.addr)
                    ADDR_TDR: bus.rdata <= tdr_o;
                    ADDR_RDR: bus.rdata <= rdr_i;
                    ADDR_LCR: bus.rdata <= lcr_o;
                    ADDR_OCR: bus.rdata <= ocr_o;
                    ADDR_LSR: bus.rdata <= lsr_i;
                    ADDR_FCR: bus.rdata <= fcr_o;
                    ADDR_IER: bus.rdata <= ier_o;
                    ADDR_IIR: bus.rdata <= iir_i;
                    ADDR_HCR: bus.rdata <= hcr_o;
                    default: begin
                        bus.rdata    <= '0;
                        bus.addr_err <= 1'b1;
                    end
                endcase
            end
        end
    end

    a_start_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        ocr_o[OCR_START] |=> !ocr_o[OCR_START]);

endmodule

// File: src/uart_apb_pkg.sv
package uart_apb_pkg;

    typedef logic [11:0] reg_addr_t;
    typedef logic [31:0] reg_word_t;
    typedef logic [3:0]  byte_strb_t;
    typedef logic [7:0]  uart_byte_t;
    typedef logic [15:0] baud_div_t;   // Clock cycles per serial bit.

    // Register map in byte offsets.
    localparam reg_addr_t ADDR_TDR = 12'h000;
    localparam reg_addr_t ADDR_RDR = 12'h004;
    localparam reg_addr_t ADDR_LCR = 12'h008;
    localparam reg_addr_t ADDR_OCR = 12'h00C;
    localparam reg_addr_t ADDR_LSR = 12'h010;
    localparam reg_addr_t ADDR_FCR = 12'h014;
    localparam reg_addr_t ADDR_IER = 12'h018;
    localparam reg_addr_t ADDR_IIR = 12'h01C;
    localparam reg_addr_t ADDR_HCR = 12'h020;

    localparam int OCR_START     = 1;
    localparam int FCR_RX_EN     = 0;
    localparam int HCR_LOOPBACK  = 0;
    localparam int LSR_RX_VALID  = 0;
    localparam int LSR_TX_BUSY   = 1;
    localparam int LSR_FRAME_ERR = 2;

    // Shared by IER and IIR.
    localparam int INT_RX = 0;
    localparam int INT_TX = 1;

    typedef enum logic [1:0] {IDLE, ACCESS, DONE} apb_state_e;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

// File: src/uart_apb_top.sv
`timescale 1ns/1ps

module uart_apb_top import uart_apb_pkg::*; #(
    parameter int SYNC_STAGES = 2
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  reg_addr_t  paddr_i,
    input  reg_word_t  pwdata_i,
    input  byte_strb_t pstrb_i,
    output reg_word_t  prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,
    output logic       uart_tx_o,
    input  logic       uart_rx_i,
    output logic       irq_o
);

    reg_word_t  tdr, lcr, ocr, fcr, ier, hcr;
    reg_word_t  rdr, lsr, iir;
    uart_byte_t rx_data;
    logic       rdr_read;
    logic       tx_busy;
    logic       rx_valid;
    logic       frame_err;

    reg_bus_if bus ();

    assign rdr = {24'd0, rx_data};

    apb_decode u_decode (
        .clk(clk), .reset_n(reset_n),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i), .pstrb_i(pstrb_i),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o),
        .bus(bus.decode)
    );

    register_file u_regs (
        .clk(clk), .reset_n(reset_n), .bus(bus.regs),
        .tdr_o(tdr), .lcr_o(lcr), .ocr_o(ocr), .fcr_o(fcr), .ier_o(ier), .hcr_o(hcr),
        .rdr_i(rdr), .lsr_i(lsr), .iir_i(iir), .rdr_read_o(rdr_read)
    );

    uart_tx u_tx (
        .clk(clk), .reset_n(reset_n),
        .start_i(ocr[OCR_START]), .data_i(tdr[7:0]), .divisor_i(lcr[15:0]),
        .tx_o(uart_tx_o), .busy_o(tx_busy)
    );

    uart_rx #(.SYNC_STAGES(SYNC_STAGES)) u_rx (
        .clk(clk), .reset_n(reset_n),
        .rx_i(uart_rx_i), .loop_tx_i(uart_tx_o), .loopback_i(hcr[HCR_LOOPBACK]),
        .enable_i(fcr[FCR_RX_EN]), .divisor_i(lcr[15:0]), .rdr_read_i(rdr_read),
        .data_o(rx_data), .valid_o(rx_valid), .frame_err_o(frame_err)
    );

    uart_status u_status (
        .tx_busy_i(tx_busy), .rx_valid_i(rx_valid), .frame_err_i(frame_err),
        .ier_i(ier), .lsr_o(lsr), .iir_o(iir), .irq_o(irq_o)
    );

endmodule

// File: src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_apb_pkg::*; #(
    parameter int SYNC_STAGES = 2
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       rx_i,
    input  logic       loop_tx_i,
    input  logic       loopback_i,
    input  logic       enable_i,
    input  baud_div_t  divisor_i,
    input  logic       rdr_read_i,
    output uart_byte_t data_o,
    output logic       valid_o,
    output logic       frame_err_o
);

    rx_state_e              state;
    logic [SYNC_STAGES-1:0] sync;
    logic                   rx_s;
    logic                   rx_prev;
    baud_div_t              cnt;
    logic [2:0]             bit_idx;
    uart_byte_t             shift;
    logic                   bit_end;
    logic                   half_bit;

    assign rx_s     = sync[SYNC_STAGES-1];
    assign bit_end  = (cnt == divisor_i - 16'd1);
    assign half_bit = (cnt == (divisor_i >> 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sync        <= '1;
            rx_prev     <= 1'b1;
            state       <= RX_IDLE;
            cnt         <= '0;
            bit_idx     <= '0;
            data_o      <= '0;
            valid_o     <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            sync    <= {sync[SYNC_STAGES-2:0], loopback_i ? loop_tx_i : rx_i};
            rx_prev <= rx_s;
            cnt     <= cnt + 16'd1;
            if (rdr_read_i) begin
                valid_o <= 1'b0;
            end
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (enable_i && rx_prev && !rx_s) state <= RX_START;   // Falling edge.
                end
                RX_START: if (half_bit) begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    state   <= rx_s ? RX_IDLE : RX_DATA;   // Glitch returns to idle.
                end
                RX_DATA: if (bit_end) begin
                    cnt     <= '0;
                    shift   <= {rx_s, shift[7:1]};
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (bit_end) begin
                    data_o      <= shift;
                    valid_o     <= 1'b1;
                    frame_err_o <= ~rx_s;   // Stop bit must be high.
                    state       <= RX_IDLE;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// File: src/uart_status.sv
`timescale 1ns/1ps

module uart_status import uart_apb_pkg::*; (
    input  logic      tx_busy_i,
    input  logic      rx_valid_i,
    input  logic      frame_err_i,
    input  reg_word_t ier_i,
    output reg_word_t lsr_o,
    output reg_word_t iir_o,
    output logic      irq_o
);

    logic [1:0] pending;

    always_comb begin
        pending         = '0;
        pending[INT_RX] = rx_valid_i;
        pending[INT_TX] = ~tx_busy_i;   // Transmitter idle.

        lsr_o                = '0;
        lsr_o[LSR_RX_VALID]  = rx_valid_i;
        lsr_o[LSR_TX_BUSY]   = tx_busy_i;
        lsr_o[LSR_FRAME_ERR] = frame_err_i;

        iir_o      = '0;
        iir_o[1:0] = pending & ier_i[1:0];
    end

    assign irq_o = |iir_o;

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_apb_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       start_i,
    input  uart_byte_t data_i,
    input  baud_div_t  divisor_i,
    output logic       tx_o,
    output logic       busy_o
);

    tx_state_e  state;
    baud_div_t  cnt;
    logic [2:0] bit_idx;
    uart_byte_t shift;
    logic       bit_end;

    assign bit_end = (cnt == divisor_i - 16'd1);
    assign busy_o  = (state != TX_IDLE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx_o    <= 1'b1;   // Line idles high.
        end else begin
            cnt <= bit_end ? '0 : cnt + 16'd1;
            case (state)
                TX_IDLE: begin
                    cnt <= '0;
                    if (start_i) begin
                        shift <= data_i;
                        tx_o  <= 1'b0;   // Start bit.
                        state <= TX_START;
                    end
                end
                TX_START: if (bit_end) begin
                    tx_o    <= shift[0];   // LSB first.
                    shift   <= shift >> 1;
                    bit_idx <= '0;
                    state   <= TX_DATA;
                end
                TX_DATA: if (bit_end) begin
                    if (bit_idx == 3'd7) begin
                        tx_o  <= 1'b1;   // Stop bit.
                        state <= TX_STOP;
                    end else begin
                        tx_o    <= shift[0];
                        shift   <= shift >> 1;
                        bit_idx <= bit_idx + 3'd1;
                    end
                end
                TX_STOP: if (bit_end) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (!reset_n)
        (state == TX_IDLE) |-> tx_o);

endmodule

// File: testbench/tb_uart_apb.sv
`timescale 1ns/1ps

module tb_uart_apb import uart_apb_pkg::*; ();

    localparam int DIV      = 16;
    localparam int N_XFERS  = 150;
    localparam int N_FRAMES = 3;
    localparam int LIMIT    = N_XFERS * 4 + N_FRAMES * 10 * DIV + 2000;

    logic       clk, reset_n, psel, penable, pwrite, rx_line;
    reg_addr_t  paddr;
    reg_word_t  pwdata, prdata;
    byte_strb_t pstrb;
    logic       pready, pslverr, tx_line, irq;
    logic [31:0] lfsr = 32'h1168_e2a6;
    int         cycles = 0;
    int         frame_gap;
    reg_addr_t  wr_regs [5] = '{ADDR_TDR, ADDR_LCR, ADDR_FCR, ADDR_IER, ADDR_HCR};
    reg_addr_t  bad_regs [6] = '{12'h024, 12'h100, 12'hFFC, ADDR_RDR, ADDR_LSR, ADDR_IIR};

    uart_apb_top #(.SYNC_STAGES(2)) dut_i (
        .clk(clk), .reset_n(reset_n), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .pstrb_i(pstrb), .prdata_o(prdata),
        .pready_o(pready), .pslverr_o(pslverr), .uart_tx_o(tx_line), .uart_rx_i(rx_line),
        .irq_o(irq)
    );

    uart_apb_checker chk_i (
        .clk(clk), .reset_n(reset_n), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .pstrb_i(pstrb), .prdata_i(prdata),
        .pready_i(pready), .pslverr_i(pslverr), .uart_tx_i(tx_line), .uart_rx_i(rx_line),
        .irq_i(irq)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("run stopped, no finish after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // Galois LFSR stepped once for each bit taken.
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic apb_access(logic wr, reg_addr_t addr, reg_word_t data, byte_strb_t strb);
        psel = 1'b1;   // Setup cycle.
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = data;
        pstrb = strb;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        while (!pready) @(negedge clk);
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(reg_addr_t addr, reg_word_t data, byte_strb_t strb = 4'hF);
        apb_access(1'b1, addr, data, strb);
    endtask

    task automatic apb_read(reg_addr_t addr);
        apb_access(1'b0, addr, '0, '0);
    endtask

    task automatic wait_irq(logic level);
        while (irq !== level) @(negedge clk);
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic drive_rx_frame(uart_byte_t data, logic stop);
        logic [9:0] bits;
        bits = {stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_line = bits[i];
            repeat (DIV) @(posedge clk);
            #1;
        end
        rx_line = 1'b1;
    endtask

    initial begin
        {psel, penable, pwrite, paddr, pwdata, pstrb} = '0;
        rx_line = 1'b1;
        reset_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 reset_n = 1'b1;
        for (int n = 0; n < 8; n++) begin
            foreach (wr_regs[i]) begin
                apb_write(wr_regs[i], rand_bits(32), byte_strb_t'(rand_bits(4)));
                apb_read(wr_regs[i]);
            end
        end
        foreach (bad_regs[i]) begin
            apb_write(bad_regs[i], rand_bits(32));
            if (i < 3) apb_read(bad_regs[i]);
        end
        foreach (wr_regs[i]) apb_read(wr_regs[i]);   // Shadow unchanged.
        apb_write(ADDR_HCR, 0);
        apb_write(ADDR_FCR, 0);
        apb_write(ADDR_LCR, DIV);
        apb_write(ADDR_IER, 1 << INT_TX);
        apb_write(ADDR_TDR, rand_bits(8));
        apb_write(ADDR_OCR, 1 << OCR_START);
        apb_read(ADDR_OCR);
        apb_read(ADDR_LSR);
        wait_irq(1'b1);
        apb_read(ADDR_LSR);
        apb_write(ADDR_HCR, 1 << HCR_LOOPBACK);   // Loopback receive.
        apb_write(ADDR_FCR, 1 << FCR_RX_EN);
        apb_write(ADDR_IER, 1 << INT_RX);
        apb_write(ADDR_TDR, rand_bits(8));
        apb_write(ADDR_OCR, 1 << OCR_START);
        wait_irq(1'b1);
        apb_read(ADDR_LSR);
        for (int e = 0; e < 4; e++) begin
            apb_write(ADDR_IER, e);
            apb_read(ADDR_IIR);
        end
        apb_read(ADDR_RDR);
        apb_read(ADDR_LSR);
        for (int e = 3; e >= 0; e--) begin
            apb_write(ADDR_IER, e);
            apb_read(ADDR_IIR);
        end
        apb_write(ADDR_HCR, 0);   // Framing error from the pin.
        apb_write(ADDR_IER, 1 << INT_RX);
        drive_rx_frame(uart_byte_t'(rand_bits(8)), 1'b0);
        wait_irq(1'b1);
        apb_read(ADDR_LSR);
        apb_read(ADDR_RDR);
        repeat (10) @(posedge clk);
        frame_gap = chk_i.tx_starts - chk_i.tx_frames;
        if (frame_gap != 0) $display("%0d transmit frames never appeared on uart_tx_o", frame_gap);
        $display("errors: %0d mismatches, %0d other failures", chk_i.mism_cnt,
                 chk_i.fail_cnt + (frame_gap != 0));
        if (chk_i.mism_cnt == 0 && chk_i.fail_cnt == 0 && frame_gap == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: testbench/uart_apb_checker.sv
`timescale 1ns/1ps

module uart_apb_checker import uart_apb_pkg::*; (
    input logic       clk,
    input logic       reset_n,
    input logic       psel_i,
    input logic       penable_i,
    input logic       pwrite_i,
    input reg_addr_t  paddr_i,
    input reg_word_t  pwdata_i,
    input byte_strb_t pstrb_i,
    input reg_word_t  prdata_i,
    input logic       pready_i,
    input logic       pslverr_i,
    input logic       uart_tx_i,
    input logic       uart_rx_i,
    input logic       irq_i
);

    reg_word_t  tdr_sh, lcr_sh, ocr_sh, fcr_sh, ier_sh, hcr_sh;
    reg_word_t  exp_rdata;
    logic       exp_err;
    logic       tx_was_busy;
    logic       rx_valid_exp, ferr_exp;
    uart_byte_t tx_byte, rdr_exp;
    int         acc_cycles, tx_left, div;
    int         tx_starts = 0;
    int         tx_frames = 0;
    int         mism_cnt = 0;
    int         fail_cnt = 0;
    int         dcnt [2];
    logic [9:0] dbits [2];
    logic       line_v [2];
    logic       prev [2];

    function automatic reg_word_t strobe_merge(reg_word_t old_w, reg_word_t new_w,
                                               byte_strb_t s);
        reg_word_t r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = s[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
        end
        return r;
    endfunction

    // Expected read data and slave error for any address.
    function automatic reg_word_t expected_read(reg_addr_t a, output logic err);
        err = 1'b0;
        case (a)
            ADDR_TDR: return tdr_sh;
            ADDR_RDR: return {24'd0, rdr_exp};
            ADDR_LCR: return lcr_sh;
            ADDR_OCR: return ocr_sh;
            ADDR_LSR: return {29'd0, ferr_exp, tx_left != 0, rx_valid_exp};
            ADDR_FCR: return fcr_sh;
            ADDR_IER: return ier_sh;
            ADDR_IIR: return {30'd0, ier_sh[1:0] & {tx_left == 0, rx_valid_exp}};
            ADDR_HCR: return hcr_sh;
            default: begin
                err = 1'b1;
                return '0;
            end
        endcase
    endfunction

    function automatic logic writable(reg_addr_t a);
        return a inside {ADDR_TDR, ADDR_LCR, ADDR_OCR, ADDR_FCR, ADDR_IER, ADDR_HCR};
    endfunction

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            {tdr_sh, lcr_sh, ocr_sh, fcr_sh, ier_sh, hcr_sh} = '0;
            {rx_valid_exp, ferr_exp, rdr_exp} = '0;
            acc_cycles = 0;
            tx_left = 0;
            dcnt = '{-1, -1};
            prev = '{1'b1, 1'b1};
        end else begin
            tx_was_busy = (tx_left != 0);
            if (psel_i && penable_i && !pready_i) begin
                if (acc_cycles == 0) begin   // Registers are sampled on the en cycle.
                    exp_rdata = expected_read(paddr_i, exp_err);
                    if (pwrite_i) exp_err = !writable(paddr_i);
                    if (!pwrite_i && paddr_i == ADDR_RDR) rx_valid_exp = 1'b0;
                end else begin
                    fail_cnt++;
                    $display("transfer to %h got no pready in its second access cycle", paddr_i);
                end
                acc_cycles++;
            end
            if (tx_left > 0) tx_left--;
            if (psel_i && penable_i && pready_i) begin
                if (acc_cycles != 1) begin
                    fail_cnt++;
                    $display("transfer to %h ended after %0d access cycles", paddr_i,
                             acc_cycles + 1);
                end
                if (pslverr_i !== exp_err) begin
                    mism_cnt++;
                    $display("mismatch pslverr_o addr %h: got %h expected %h", paddr_i,
                             pslverr_i, exp_err);
                end
                if (!pwrite_i && prdata_i !== exp_rdata) begin
                    mism_cnt++;
                    $display("mismatch prdata_o addr %h: got %h expected %h", paddr_i,
                             prdata_i, exp_rdata);
                end
                if (!pwrite_i && paddr_i == ADDR_IIR && irq_i !== |exp_rdata[1:0]) begin
                    mism_cnt++;
                    $display("mismatch irq_o: got %h expected %h", irq_i, |exp_rdata[1:0]);
                end
                if (pwrite_i && !exp_err) begin
                    case (paddr_i)
                        ADDR_TDR: tdr_sh = strobe_merge(tdr_sh, pwdata_i, pstrb_i);
                        ADDR_LCR: lcr_sh = strobe_merge(lcr_sh, pwdata_i, pstrb_i);
                        ADDR_FCR: fcr_sh = strobe_merge(fcr_sh, pwdata_i, pstrb_i);
                        ADDR_IER: ier_sh = strobe_merge(ier_sh, pwdata_i, pstrb_i);
                        ADDR_HCR: hcr_sh = strobe_merge(hcr_sh, pwdata_i, pstrb_i);
                        default: begin
                            ocr_sh = strobe_merge(ocr_sh, pwdata_i, pstrb_i);
                            if (ocr_sh[OCR_START] && !tx_was_busy) begin
                                tx_left = 10 * int'(lcr_sh[15:0]);   // Ten bit periods.
                                tx_byte = tdr_sh[7:0];
                                tx_starts++;
                            end
                            ocr_sh[OCR_START] = 1'b0;
                        end
                    endcase
                end
                acc_cycles = 0;
            end else if (!(psel_i && penable_i)) begin
                acc_cycles = 0;
            end

            // Decoder 0 watches uart_tx_o and decoder 1 the receiver input.
            div = int'(lcr_sh[15:0]);
            line_v[0] = uart_tx_i;
            line_v[1] = hcr_sh[HCR_LOOPBACK] ? uart_tx_i : uart_rx_i;
            for (int k = 0; k < 2; k++) begin
                if (dcnt[k] < 0) begin
                    if (prev[k] && !line_v[k] && (k == 0 || fcr_sh[FCR_RX_EN])) dcnt[k] = 0;
                end else begin
                    dcnt[k]++;
                    if (dcnt[k] % div == div / 2) begin   // Mid-bit.
                        dbits[k][dcnt[k] / div] = line_v[k];
                        if (dcnt[k] / div == 9) begin
                            dcnt[k] = -1;
                            if (k == 0) begin
                                tx_frames++;
                                if (dbits[0][8:1] !== tx_byte || dbits[0][9] !== 1'b1) begin
                                    mism_cnt++;
                                    $display("mismatch uart_tx_o frame: got %h expected %h",
                                             dbits[0], {1'b1, tx_byte, 1'b0});
                                end
                            end else begin
                                rdr_exp = dbits[1][8:1];
                                rx_valid_exp = 1'b1;
                                ferr_exp = !dbits[1][9];
                            end
                        end
                    end
                end
                prev[k] = line_v[k];
            end
        end
    end

endmodule
